//--- audio_out_top.f
verilog/audio_out_pkg.sv
verilog/spdif_frame_tx.sv
verilog/dac_pwm.sv
verilog/audio_out_top.sv
test/audio_out_checker.sv
test/audio_out_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the audio output testbench with Verilator

LOG=sim.log
BIN=audio_out_sim

verilator --binary --timing --assert \
    -f audio_out_top.f \
    --top-module audio_out_tb \
    -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if ! grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0

//--- test/audio_out_checker.sv
/*
 * Testbench checker for the audio output path
 * Models the sample hold from the stimulus, decodes the S/PDIF line,
 * sums the DAC codes over 4096-cycle windows and counts errors
 */

`timescale 1ns/1ns

module audio_out_checker (
    input  logic        clk_2x,
    input  logic        rst_n,
    input  logic [15:0] audio_output_l,
    input  logic [15:0] audio_output_r,
    input  logic        audio_output_valid,
    input  logic [3:0]  audio_l,
    input  logic [3:0]  audio_r,
    input  logic        spdif,
    output int          error_count,
    output int          subframe_count,
    output int          block_starts,
    output int          window_count
);
    // Preambles after a low line, first half-cell in the MSB
    localparam logic [7:0] PRE_B = 8'b1110_1000;
    localparam logic [7:0] PRE_M = 8'b1110_0010;
    localparam logic [7:0] PRE_W = 8'b1110_0100;
    localparam int WINDOW = 4096;

    int err_rst = 0;
    int err_line = 0;
    int err_dac = 0;

    logic        rst_q = 1'b1;
    logic [15:0] model_l;
    logic [15:0] model_r;
    logic [15:0] model_l_d;
    logic [15:0] model_r_d;

    logic        aligned;
    logic        line_q;
    logic        prev_level;
    logic [2:0]  phase;
    logic [5:0]  hc_idx;
    logic [63:0] hc_bits;
    logic [15:0] exp_sample;

    int win_pos;
    int sum_l;
    int sum_r;
    int exp_sum_l;
    int exp_sum_r;

    assign error_count = err_rst + err_line + err_dac;

    function automatic int dac_sum_expected(input logic [15:0] s);
        logic [15:0] u;
        int hi;
        int lo;
        u = {~s[15], s[14:0]};
        hi = int'(u[15:12]);
        lo = int'(u[11:0]);
        if (hi == 15) begin
            return 15 * WINDOW;
        end
        return hi * WINDOW + lo;
    endfunction

    task automatic show_mismatch(input string name, input int expv, input int actv);
        $display("FAIL time=%0t signal=%s expected=%0h actual=%0h", $time, name, expv, actv);
    endtask

    // Outputs stay at zero in reset and on the first cycle after it
    always @(posedge clk_2x) begin
        rst_q <= rst_n;
        if (!rst_q) begin
            if (audio_l != 4'd0 || audio_r != 4'd0 || spdif != 1'b0) begin
                $display("FAIL time=%0t signal=reset_outputs expected=0 actual=%h/%h/%b",
                         $time, audio_l, audio_r, spdif);
                err_rst <= err_rst + 1;
            end
        end
    end

    // Reference sample hold, plus the value seen one edge earlier
    always @(posedge clk_2x) begin
        if (!rst_n) begin
            model_l <= '0;
            model_r <= '0;
        end else if (audio_output_valid) begin
            model_l <= audio_output_l;
            model_r <= audio_output_r;
        end
        model_l_d <= model_l;
        model_r_d <= model_r;
    end

    task automatic check_subframe(input logic [63:0] cells);
        logic [31:0] bits;
        logic [7:0]  exp_pre;
        logic [7:0]  act_pre;
        int s;
        int k;
        bits = '0;
        for (k = 0; k < 8; k++) begin
            act_pre[7-k] = cells[k] ^ prev_level;
        end
        if (subframe_count[0]) begin
            exp_pre = PRE_W;
        end else if ((subframe_count / 2) % 192 == 0) begin
            exp_pre = PRE_B;
        end else begin
            exp_pre = PRE_M;
        end
        if (act_pre == PRE_B) begin
            block_starts = block_starts + 1;
        end
        if (act_pre != exp_pre) begin
            show_mismatch("spdif_preamble", int'(exp_pre), int'(act_pre));
            err_line = err_line + 1;
        end
        for (s = 4; s < 32; s++) begin
            if (cells[2*s] == cells[2*s-1]) begin
                $display("Biphase error at %0t: no transition at start of slot %0d", $time, s);
                err_line = err_line + 1;
            end
            bits[s] = cells[2*s] ^ cells[2*s+1];
        end
        if (bits[27:12] != exp_sample) begin
            show_mismatch(subframe_count[0] ? "spdif_right" : "spdif_left",
                          int'(exp_sample), int'(bits[27:12]));
            err_line = err_line + 1;
        end
        if (bits[11:4] != 8'h00 || bits[30:28] != 3'b000) begin
            show_mismatch("spdif_pad_vuc", 0, int'({bits[30:28], bits[11:4]}));
            err_line = err_line + 1;
        end
        if (^bits[31:4]) begin
            $display("Parity error at %0t: subframe %0d has odd parity", $time, subframe_count);
            err_line = err_line + 1;
        end
        subframe_count = subframe_count + 1;
    endtask

    // S/PDIF decoder, aligned on the first line transition
    always @(posedge clk_2x) begin
        logic [63:0] cells;
        if (!rst_n) begin
            aligned <= 1'b0;
            line_q <= 1'b0;
            prev_level <= 1'b0;
            subframe_count = 0;
            block_starts = 0;
        end else if (!aligned) begin
            if (spdif != line_q) begin
                aligned <= 1'b1;
                phase <= 3'd1;
                hc_idx <= 6'd0;
                exp_sample <= model_l_d;
            end
            line_q <= spdif;
        end else begin
            if (phase != 3'd0 && spdif != line_q) begin
                $display("Line error at %0t: spdif moved inside a half-cell", $time);
                err_line = err_line + 1;
            end
            line_q <= spdif;
            if (phase == 3'd5) begin
                phase <= 3'd0;
                hc_idx <= hc_idx + 6'd1;
            end else begin
                phase <= phase + 3'd1;
            end
            if (phase == 3'd0 && hc_idx == 6'd0) begin
                exp_sample <= subframe_count[0] ? model_r_d : model_l_d;
            end
            if (phase == 3'd3) begin
                cells = hc_bits;
                cells[hc_idx] = spdif;
                hc_bits <= cells;
                if (hc_idx == 6'd63) begin
                    check_subframe(cells);
                    prev_level <= spdif;
                end
            end
        end
    end

    // DAC sums over 4096 cycles from two cycles after each strobe
    always @(posedge clk_2x) begin
        if (!rst_n) begin
            win_pos <= -2;
            window_count <= 0;
        end else if (audio_output_valid) begin
            win_pos <= -1;
            exp_sum_l <= dac_sum_expected(audio_output_l);
            exp_sum_r <= dac_sum_expected(audio_output_r);
        end else if (win_pos == -1) begin
            win_pos <= 0;
            sum_l <= 0;
            sum_r <= 0;
        end else if (win_pos >= 0 && win_pos < WINDOW) begin
            if (win_pos == WINDOW - 1) begin
                if (sum_l + int'(audio_l) != exp_sum_l) begin
                    show_mismatch("audio_l_sum", exp_sum_l, sum_l + int'(audio_l));
                    err_dac = err_dac + 1;
                end
                if (sum_r + int'(audio_r) != exp_sum_r) begin
                    show_mismatch("audio_r_sum", exp_sum_r, sum_r + int'(audio_r));
                    err_dac = err_dac + 1;
                end
                window_count <= window_count + 1;
            end
            sum_l <= sum_l + int'(audio_l);
            sum_r <= sum_r + int'(audio_r);
            win_pos <= win_pos + 1;
        end
    end

endmodule

//--- test/audio_out_tb.sv
/*
 * Testbench top for the audio output path
 * Clock, reset, stimulus table with input noise, watchdog and report
 */

`timescale 1ns/1ns

module audio_out_tb;

    localparam int ROWS = 8;
    localparam int CLK_NS = 8;
    localparam int BLOCK_CYCLES = 192 * 2 * 64 * 6;

    // Left sample, right sample, hold cycles
    localparam logic [15:0] ROW_L [ROWS] = '{
        16'h0000, 16'h8000, 16'h7fff, 16'h1234,
        16'h8000, 16'h0a5c, 16'h7fff, 16'hc3e7
    };
    localparam logic [15:0] ROW_R [ROWS] = '{
        16'h0000, 16'h8000, 16'h7fff, 16'hedcb,
        16'h7fff, 16'hf3a1, 16'h8000, 16'h3c18
    };
    localparam int ROW_HOLD [ROWS] = '{
        20000, 20000, 20000, 20000, 20000, 20000, 20000, 20000
    };

    logic        clk_2x;
    logic        rst_n;
    logic [15:0] audio_output_l;
    logic [15:0] audio_output_r;
    logic        audio_output_valid;
    logic [3:0]  audio_l;
    logic [3:0]  audio_r;
    logic        spdif;

    int error_count;
    int subframe_count;
    int block_starts;
    int window_count;
    int end_errors;

    function automatic int total_hold();
        int sum;
        sum = 0;
        for (int i = 0; i < ROWS; i++) begin
            sum += ROW_HOLD[i];
        end
        return sum;
    endfunction

    audio_out_top dut (
        .clk_2x             (clk_2x),
        .rst_n              (rst_n),
        .audio_output_l     (audio_output_l),
        .audio_output_r     (audio_output_r),
        .audio_output_valid (audio_output_valid),
        .audio_l            (audio_l),
        .audio_r            (audio_r),
        .spdif              (spdif)
    );

    audio_out_checker audio_check (
        .clk_2x             (clk_2x),
        .rst_n              (rst_n),
        .audio_output_l     (audio_output_l),
        .audio_output_r     (audio_output_r),
        .audio_output_valid (audio_output_valid),
        .audio_l            (audio_l),
        .audio_r            (audio_r),
        .spdif              (spdif),
        .error_count        (error_count),
        .subframe_count     (subframe_count),
        .block_starts       (block_starts),
        .window_count       (window_count)
    );

    initial begin
        clk_2x = 1'b0;
        forever #(CLK_NS / 2) clk_2x = ~clk_2x;
    end

    // Watchdog
    initial begin
        #((total_hold() + BLOCK_CYCLES) * 2 * CLK_NS);
        $display("Timeout: the test did not finish in the expected time");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        end_errors = 0;
        void'($urandom(32'h76ed9975));
        rst_n = 1'b0;
        audio_output_l = '0;
        audio_output_r = '0;
        audio_output_valid = 1'b0;
        repeat (5) @(negedge clk_2x);
        rst_n = 1'b1;

        for (int row = 0; row < ROWS; row++) begin
            @(negedge clk_2x);
            audio_output_l = ROW_L[row];
            audio_output_r = ROW_R[row];
            audio_output_valid = 1'b1;
            @(negedge clk_2x);
            audio_output_valid = 1'b0;
            // Noise on the data inputs with the strobe low
            repeat (ROW_HOLD[row]) begin
                @(negedge clk_2x);
                audio_output_l = 16'($urandom);
                audio_output_r = 16'($urandom);
            end
        end
        repeat (10) @(negedge clk_2x);

        if (window_count != ROWS) begin
            $display("Only %0d of %0d DAC windows were checked", window_count, ROWS);
            end_errors++;
        end
        if (block_starts < 2) begin
            $display("No full channel-status block was seen on the line");
            end_errors++;
        end
        if (subframe_count < 2 * 192) begin
            $display("Too few S/PDIF subframes were decoded");
            end_errors++;
        end

        $display("errors=%0d subframes=%0d block_starts=%0d dac_windows=%0d",
                 error_count + end_errors, subframe_count, block_starts, window_count);
        if (error_count + end_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- verilog/audio_out_pkg.sv
/*
 * Shared constants for the board audio output path
 * Sample and DAC widths, S/PDIF half-cell timing, preamble patterns
 * and the subframe word with its field and raw views
 */

package audio_out_pkg;

    // Audio sample and analog DAC widths
    localparam int PCM_BITS      = 16;
    localparam int DAC_BITS      = 4;
    localparam int DAC_FRAC_BITS = PCM_BITS - DAC_BITS;

    // Full-scale DAC code, also the saturation limit
    localparam logic [DAC_BITS-1:0] DAC_MAX = '1;

    // S/PDIF line timing in clk_2x cycles
    localparam int HALF_CELL_CYCLES = 6;
    localparam int HALF_CELL_BITS   = $clog2(HALF_CELL_CYCLES);

    // Last cycle of a half-cell
    localparam logic [HALF_CELL_BITS-1:0] HALF_CELL_LAST =
        HALF_CELL_BITS'(HALF_CELL_CYCLES - 1);

    // Subframe framing
    localparam int SUBFRAME_BITS      = 32;
    localparam int HALF_CELL_IDX_BITS = $clog2(2 * SUBFRAME_BITS);
    localparam int PREAMBLE_SLOTS     = 4;
    localparam int PREAMBLE_HALF_CELLS = 2 * PREAMBLE_SLOTS;
    localparam int AUDIO_PAD_BITS     = 8;

    // Channel-status block length in frames
    localparam int FRAMES_PER_BLOCK = 192;
    localparam int FRAME_CNT_BITS   = $clog2(FRAMES_PER_BLOCK);

    localparam logic [FRAME_CNT_BITS-1:0] FRAME_LAST =
        FRAME_CNT_BITS'(FRAMES_PER_BLOCK - 1);

    // Preambles as sent after a low line, first half-cell in the MSB
    // The transmitter inverts them when the line is high
    localparam logic [PREAMBLE_HALF_CELLS-1:0] PREAMBLE_B = 8'b1110_1000;
    localparam logic [PREAMBLE_HALF_CELLS-1:0] PREAMBLE_M = 8'b1110_0010;
    localparam logic [PREAMBLE_HALF_CELLS-1:0] PREAMBLE_W = 8'b1110_0100;

    // Subframe fields, MSB first as packed structs go
    // Bit 0 is the first slot on the line
    typedef struct packed {
        logic                      parity;
        logic                      channel_status;
        logic                      user;
        logic                      validity;
        logic [PCM_BITS-1:0]       sample;
        logic [AUDIO_PAD_BITS-1:0] audio_pad;
        logic [PREAMBLE_SLOTS-1:0] preamble;
    } spdif_subframe_fields_t;

    // Built through the fields, shifted out LSB first through raw
    typedef union packed {
        spdif_subframe_fields_t   fields;
        logic [SUBFRAME_BITS-1:0] raw;
    } spdif_subframe_u;

endpackage

//--- verilog/audio_out_top.sv
/*
 * Board audio output top
 * Holds the latest valid stereo sample pair and drives the S/PDIF
 * transmitter and one 4-bit DAC modulator per channel
 */

`timescale 1ns/1ns

module audio_out_top (
    input  logic                               clk_2x,
    input  logic                               rst_n,

    input  logic [audio_out_pkg::PCM_BITS-1:0] audio_output_l,
    input  logic [audio_out_pkg::PCM_BITS-1:0] audio_output_r,
    input  logic                               audio_output_valid,

    output logic [audio_out_pkg::DAC_BITS-1:0] audio_l,
    output logic [audio_out_pkg::DAC_BITS-1:0] audio_r,
    output logic                               spdif
);
    import audio_out_pkg::*;

    logic [PCM_BITS-1:0] held_l;
    logic [PCM_BITS-1:0] held_r;

    // Sample hold
    // A new pair just replaces the old one, nothing is acknowledged
    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            held_l <= '0;
            held_r <= '0;
        end else if (audio_output_valid) begin
            held_l <= audio_output_l;
            held_r <= audio_output_r;
        end
    end

    // Digital output
    // Left and right subframes alternate on the line
    spdif_frame_tx spdif_tx (
        .clk_2x         (clk_2x),
        .rst_n          (rst_n),
        .held_l         (held_l),
        .held_r         (held_r),
        .channel_select (),
        .spdif          (spdif)
    );

    // Analog outputs
    dac_pwm dac_left (
        .clk_2x (clk_2x),
        .rst_n  (rst_n),
        .pcm    (held_l),
        .dac    (audio_l)
    );

    dac_pwm dac_right (
        .clk_2x (clk_2x),
        .rst_n  (rst_n),
        .pcm    (held_r),
        .dac    (audio_r)
    );

    // An unknown strobe would corrupt both held samples at once
    a_valid_known: assert property (
        @(posedge clk_2x) disable iff (!rst_n)
        !$isunknown(audio_output_valid)
    );

endmodule

//--- verilog/dac_pwm.sv
/*
 * First-order 4-bit DAC modulator
 * Offset-binary conversion and error-feedback accumulator
 * on the low sample bits, with a registered output code
 */

`timescale 1ns/1ns

module dac_pwm (
    input  logic                               clk_2x,
    input  logic                               rst_n,
    input  logic [audio_out_pkg::PCM_BITS-1:0] pcm,
    output logic [audio_out_pkg::DAC_BITS-1:0] dac
);
    import audio_out_pkg::*;

    logic [PCM_BITS-1:0]      pcm_u;
    logic [DAC_BITS-1:0]      hi;
    logic [DAC_FRAC_BITS-1:0] lo;

    logic [DAC_FRAC_BITS-1:0] acc;
    logic [DAC_FRAC_BITS:0]   acc_sum;
    logic [DAC_BITS:0]        dac_sum;

    // Signed to offset binary
    assign pcm_u = {~pcm[PCM_BITS-1], pcm[PCM_BITS-2:0]};

    // Coarse code and the residue left for the accumulator
    assign hi = pcm_u[PCM_BITS-1 -: DAC_BITS];
    assign lo = pcm_u[DAC_FRAC_BITS-1:0];

    // Carry out of the residue sum bumps the code by one
    assign acc_sum = {1'b0, acc} + {1'b0, lo};
    assign dac_sum = {1'b0, hi} + {{DAC_BITS{1'b0}}, acc_sum[DAC_FRAC_BITS]};

    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            acc <= '0;
            dac <= '0;
        end else begin
            acc <= acc_sum[DAC_FRAC_BITS-1:0];

            // Full scale stays at full scale
            if (dac_sum[DAC_BITS]) begin
                dac <= DAC_MAX;
            end else begin
                dac <= dac_sum[DAC_BITS-1:0];
            end
        end
    end

    // Output never strays more than one step above the coarse code
    a_dac_range: assert property (
        @(posedge clk_2x) disable iff (!rst_n)
        $past(rst_n) |->
            (dac == $past(hi)) ||
            (($past(hi) != DAC_MAX) && (dac == $past(hi) + 1'b1))
    );

endmodule

//--- verilog/spdif_frame_tx.sv
/*
 * S/PDIF transmitter
 * Builds one subframe per side from the held samples, picks the
 * B/M/W preamble and sends it with biphase-mark coding
 */

`timescale 1ns/1ns

module spdif_frame_tx (
    input  logic                              clk_2x,
    input  logic                              rst_n,
    input  logic [audio_out_pkg::PCM_BITS-1:0] held_l,
    input  logic [audio_out_pkg::PCM_BITS-1:0] held_r,
    output logic                              channel_select,
    output logic                              spdif
);
    import audio_out_pkg::*;

    logic [HALF_CELL_BITS-1:0]      hc_cnt;
    logic [HALF_CELL_IDX_BITS-1:0]  cell_idx;
    logic [FRAME_CNT_BITS-1:0]      frame_cnt;

    spdif_subframe_u                shreg;
    spdif_subframe_u                word_next;
    logic [PCM_BITS-1:0]            sample_sel;

    logic [PREAMBLE_HALF_CELLS-1:0] pre_pat;
    logic [PREAMBLE_HALF_CELLS-1:0] pre_next;
    logic                           pre_inv;

    logic                           cell_start;
    logic                           sf_start;
    logic                           sf_end;
    logic                           in_preamble;

    // cell_idx points at the half-cell emitted on the next cell_start
    assign cell_start  = (hc_cnt == '0);
    assign sf_start    = cell_start && (cell_idx == '0);
    assign sf_end      = (hc_cnt == HALF_CELL_LAST) && (cell_idx == '0);
    assign in_preamble = (cell_idx < HALF_CELL_IDX_BITS'(PREAMBLE_HALF_CELLS));

    // Half-cell timing
    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            hc_cnt   <= '0;
            cell_idx <= '0;
        end else begin
            if (hc_cnt == HALF_CELL_LAST) begin
                hc_cnt <= '0;
            end else begin
                hc_cnt <= hc_cnt + 1'b1;
            end

            // 64 half-cells per subframe, wraps on its own
            if (cell_start) begin
                cell_idx <= cell_idx + 1'b1;
            end
        end
    end

    // Side flag flips in the last cycle of a subframe, so the new side
    // is already visible when the next word is assembled
    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            channel_select <= 1'b0;
            frame_cnt      <= '0;
        end else if (sf_end) begin
            channel_select <= ~channel_select;

            // A frame ends after its right subframe
            if (channel_select) begin
                if (frame_cnt == FRAME_LAST) begin
                    frame_cnt <= '0;
                end else begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

    // Subframe word for the side about to be sent
    always_comb begin
        sample_sel = channel_select ? held_r : held_l;

        word_next.raw           = '0;
        word_next.fields.sample = sample_sel;

        // Even parity over slots 4 to 31
        word_next.fields.parity = ^word_next.raw[SUBFRAME_BITS-2:PREAMBLE_SLOTS];
    end

    // B opens each block on the left side
    always_comb begin
        if (channel_select) begin
            pre_next = PREAMBLE_W;
        end else if (frame_cnt == '0) begin
            pre_next = PREAMBLE_B;
        end else begin
            pre_next = PREAMBLE_M;
        end
    end

    // Subframe and preamble shifters
    always_ff @(posedge clk_2x) begin
        if (sf_start) begin
            shreg   <= word_next;
            pre_pat <= pre_next << 1;
            pre_inv <= spdif;
        end else if (cell_start) begin
            pre_pat <= pre_pat << 1;

            // Next slot's bit moves into bit 0 at the end of each slot
            if (cell_idx[0]) begin
                shreg.raw <= shreg.raw >> 1;
            end
        end
    end

    // Line register
    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            spdif <= 1'b0;
        end else if (cell_start) begin
            if (sf_start) begin
                spdif <= pre_next[PREAMBLE_HALF_CELLS-1] ^ spdif;
            end else if (in_preamble) begin
                spdif <= pre_pat[PREAMBLE_HALF_CELLS-1] ^ pre_inv;
            end else if (!cell_idx[0]) begin
                // Every data slot opens with a transition
                spdif <= ~spdif;
            end else if (shreg.raw[0]) begin
                // Mid-slot transition marks a one
                spdif <= ~spdif;
            end
        end
    end

    // The line only moves on a half-cell edge
    a_spdif_on_cell: assert property (
        @(posedge clk_2x) disable iff (!rst_n)
        $changed(spdif) |-> $past(cell_start)
    );

    // A side change is seen exactly when a subframe starts
    a_select_at_start: assert property (
        @(posedge clk_2x) disable iff (!rst_n)
        $changed(channel_select) |-> sf_start
    );

    a_frame_range: assert property (
        @(posedge clk_2x) disable iff (!rst_n)
        frame_cnt < FRAME_CNT_BITS'(FRAMES_PER_BLOCK)
    );

endmodule
